/* logic/nnFixedPkg.sv */
`default_nettype none

package nnFixedPkg;

	// the layer shape is fixed at build time.
	localparam int inputCount = 15;
	localparam int neuronCount = 4;

	// weights and biases carry 13 fraction bits.
	localparam int fracBits = 13;

	// an activation is a plain 16-bit unsigned value.
	localparam int activationWidth = 16;

	// the weight memory reserves this many words per neuron.
	// only the first inputCount of them are used.
	localparam int weightSlots = 16;

	typedef logic [activationWidth-1:0] activation_t;

	typedef logic signed [15:0] weight_t;

	// the accumulator wraps at 32 bits.
	typedef logic signed [31:0] accum_t;

	typedef logic [3:0] inputIndex_t;

	typedef logic [1:0] neuronIndex_t;

endpackage

`default_nettype wire

/* logic/nnRegPkg.sv */
`default_nettype none

package nnRegPkg;

	localparam int apbAddrWidth = 12;

	typedef logic [apbAddrWidth-1:0] apbAddr_t;

	// writing a one to startBit of the control word launches the layer.
	localparam apbAddr_t ctrlAddr = 12'h000;
	localparam int startBit = 0;

	// status word is read-only.
	localparam apbAddr_t statusAddr = 12'h004;
	localparam int busyBit = 0;
	localparam int doneBit = 1;

	// all tables are one 32-bit word per entry.
	localparam apbAddr_t inputBase = 12'h040;
	localparam apbAddr_t outputBase = 12'h080;
	localparam apbAddr_t biasBase = 12'h100;

	// weight word index is neuron * 16 + input.
	localparam apbAddr_t weightBase = 12'h200;

endpackage

`default_nettype wire

/* logic/macBus.sv */
`timescale 1ns/1ps
`default_nettype none

interface macBus;

	logic clear;
	logic accumulate;
	nnFixedPkg::activation_t activation;
	nnFixedPkg::weight_t weight;
	nnFixedPkg::weight_t bias;
	nnFixedPkg::activation_t result;
	logic resultValid;

	modport sequencer (
		output clear,
		output accumulate,
		output activation,
		output weight,
		output bias,
		input resultValid
	);

	modport mac (
		input clear,
		input accumulate,
		input activation,
		input weight,
		input bias,
		output result,
		output resultValid
	);

endinterface

`default_nettype wire

/* logic/layerControl.sv */
`timescale 1ns/1ps
`default_nettype none

module layerControl (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [nnRegPkg::apbAddrWidth-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic weightWrite,
	output logic biasWrite,
	output logic inputWrite,
	output logic [5:0] weightIndex,
	output nnFixedPkg::neuronIndex_t biasIndex,
	output nnFixedPkg::inputIndex_t inputIndex,
	output nnFixedPkg::weight_t writeData,
	output nnFixedPkg::neuronIndex_t readNeuron,
	output nnFixedPkg::inputIndex_t readInput,
	output nnFixedPkg::neuronIndex_t outputSelect,
	input nnFixedPkg::activation_t storedActivation,
	input nnFixedPkg::weight_t storedWeight,
	input nnFixedPkg::weight_t storedBias,
	input nnFixedPkg::activation_t outputValue,
	macBus.sequencer mac
);

	localparam nnRegPkg::apbAddr_t inputSpan = nnRegPkg::apbAddr_t'(4 * nnFixedPkg::inputCount);
	localparam nnRegPkg::apbAddr_t outputSpan = nnRegPkg::apbAddr_t'(4 * nnFixedPkg::neuronCount);
	localparam nnRegPkg::apbAddr_t weightSpan =
		nnRegPkg::apbAddr_t'(4 * nnFixedPkg::weightSlots * nnFixedPkg::neuronCount);

	typedef enum logic [1:0] {idle, clearing, accumulating, rectifying} seqState_t;

	seqState_t state;
	nnFixedPkg::neuronIndex_t neuron;
	nnFixedPkg::inputIndex_t inputCounter;
	logic done;
	logic busy;
	logic access;
	logic aligned;
	logic ctrlHit;
	logic statusHit;
	logic inputHit;
	logic outputHit;
	logic biasHit;
	logic weightHit;
	logic tableHit;
	logic tableWriteOk;
	logic start;
	nnRegPkg::apbAddr_t inputOffset;
	nnRegPkg::apbAddr_t outputOffset;
	nnRegPkg::apbAddr_t biasOffset;
	nnRegPkg::apbAddr_t weightOffset;

	assign busy = (state != idle);
	assign access = psel & penable;
	assign aligned = (paddr[1:0] == 2'b00);

	// an offset below its base wraps high and fails the span check.
	assign inputOffset = paddr - nnRegPkg::inputBase;
	assign outputOffset = paddr - nnRegPkg::outputBase;
	assign biasOffset = paddr - nnRegPkg::biasBase;
	assign weightOffset = paddr - nnRegPkg::weightBase;

	assign ctrlHit = (paddr == nnRegPkg::ctrlAddr);
	assign statusHit = (paddr == nnRegPkg::statusAddr);
	assign inputHit = aligned && (inputOffset < inputSpan);
	assign outputHit = aligned && (outputOffset < outputSpan);
	assign biasHit = aligned && (biasOffset < outputSpan);
	// slot 15 of every neuron is a hole in the weight map.
	assign weightHit = aligned && (weightOffset < weightSpan) &&
		(weightOffset[5:2] < nnFixedPkg::inputIndex_t'(nnFixedPkg::inputCount));
	assign tableHit = inputHit | biasHit | weightHit;

	assign tableWriteOk = access && pwrite && !busy;
	assign weightWrite = tableWriteOk && weightHit;
	assign biasWrite = tableWriteOk && biasHit;
	assign inputWrite = tableWriteOk && inputHit;
	assign weightIndex = weightOffset[7:2];
	assign biasIndex = biasOffset[3:2];
	assign inputIndex = inputOffset[5:2];
	assign writeData = pwdata[15:0];
	assign start = access && pwrite && ctrlHit && pwdata[nnRegPkg::startBit] && !busy;

	assign pready = 1'b1;
	assign outputSelect = outputOffset[3:2];

	always_comb
	begin
		prdata = '0;
		if (statusHit)
		begin
			prdata[nnRegPkg::busyBit] = busy;
			prdata[nnRegPkg::doneBit] = done;
		end
		else if (outputHit)
		begin
			prdata[nnFixedPkg::activationWidth-1:0] = outputValue;
		end
	end

	// read-only words count as unmapped for writes.
	always_comb
	begin
		if (!access)
			pslverr = 1'b0;
		else if (pwrite)
			pslverr = !(ctrlHit || tableHit) || (busy && tableHit) ||
				(busy && ctrlHit && pwdata[nnRegPkg::startBit]);
		else
			pslverr = !(ctrlHit || statusHit || outputHit || tableHit);
	end

	assign readNeuron = neuron;
	assign readInput = inputCounter;
	assign mac.clear = (state == clearing);
	assign mac.accumulate = (state == accumulating);
	assign mac.activation = storedActivation;
	assign mac.weight = storedWeight;
	assign mac.bias = storedBias;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			neuron <= '0;
			inputCounter <= '0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (start)
					begin
						state <= clearing;
						neuron <= '0;
						inputCounter <= '0;
						done <= 1'b0;
					end
				end
				clearing:
				begin
					state <= accumulating;
					inputCounter <= '0;
				end
				accumulating:
				begin
					if (inputCounter == nnFixedPkg::inputIndex_t'(nnFixedPkg::inputCount - 1))
						state <= rectifying;
					else
						inputCounter <= inputCounter + 1'b1;
				end
				default:
				begin
					// the result is captured at the end of this cycle.
					if (mac.resultValid)
					begin
						if (neuron == nnFixedPkg::neuronIndex_t'(nnFixedPkg::neuronCount - 1))
						begin
							state <= idle;
							done <= 1'b1;
						end
						else
						begin
							state <= clearing;
							neuron <= neuron + 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/weightStore.sv */
`timescale 1ns/1ps
`default_nettype none

module weightStore (
	input logic clk,
	input logic weightWrite,
	input logic biasWrite,
	input logic [5:0] weightIndex,
	input nnFixedPkg::neuronIndex_t biasIndex,
	input nnFixedPkg::weight_t writeData,
	input nnFixedPkg::neuronIndex_t readNeuron,
	input nnFixedPkg::inputIndex_t readInput,
	output nnFixedPkg::weight_t storedWeight,
	output nnFixedPkg::weight_t storedBias
);

	// sixteen slots per neuron keep the index a simple concatenation.
	nnFixedPkg::weight_t weights [nnFixedPkg::neuronCount * nnFixedPkg::weightSlots] =
		'{default: '0};
	nnFixedPkg::weight_t biases [nnFixedPkg::neuronCount] = '{default: '0};

	always_ff @(posedge clk)
	begin
		if (weightWrite)
		begin
			weights[weightIndex] <= writeData;
		end
		if (biasWrite)
		begin
			biases[biasIndex] <= writeData;
		end
	end

	assign storedWeight = weights[{readNeuron, readInput}];
	assign storedBias = biases[readNeuron];

endmodule

`default_nettype wire

/* logic/activationBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module activationBuffer (
	input logic clk,
	input logic reset,
	input logic inputWrite,
	input nnFixedPkg::inputIndex_t inputIndex,
	input nnFixedPkg::activation_t writeData,
	input nnFixedPkg::inputIndex_t readInput,
	output nnFixedPkg::activation_t storedActivation,
	input nnFixedPkg::neuronIndex_t readNeuron,
	macBus.mac mac,
	input nnFixedPkg::neuronIndex_t outputSelect,
	output nnFixedPkg::activation_t outputValue
);

	nnFixedPkg::activation_t inputs [nnFixedPkg::inputCount] = '{default: '0};
	nnFixedPkg::activation_t outputs [nnFixedPkg::neuronCount];

	always_ff @(posedge clk)
	begin
		if (inputWrite)
		begin
			inputs[inputIndex] <= writeData;
		end
	end

	// the sequencer still points at the finishing neuron while resultValid is high.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < nnFixedPkg::neuronCount; n++)
			begin
				outputs[n] <= '0;
			end
		end
		else if (mac.resultValid)
		begin
			outputs[readNeuron] <= mac.result;
		end
	end

	assign storedActivation = inputs[readInput];
	assign outputValue = outputs[outputSelect];

endmodule

`default_nettype wire

/* logic/neuronMac.sv */
`timescale 1ns/1ps
`default_nettype none

module neuronMac (
	input logic clk,
	input logic reset,
	macBus.mac mac
);

	localparam int sliceLow = nnFixedPkg::fracBits;
	localparam int sliceHigh = nnFixedPkg::fracBits + nnFixedPkg::activationWidth - 1;

	nnFixedPkg::accum_t accumulator;
	nnFixedPkg::accum_t activationWide;
	nnFixedPkg::accum_t weightWide;
	nnFixedPkg::accum_t product;
	nnFixedPkg::accum_t sum;
	nnFixedPkg::accum_t biasAligned;
	nnFixedPkg::activation_t rectified;
	logic accumulatePrev;

	// the activation is unsigned and zero-extends, the weight sign-extends.
	assign activationWide = nnFixedPkg::accum_t'(mac.activation);
	assign weightWide = nnFixedPkg::accum_t'(mac.weight);

	// only the low 32 bits of the product are kept.
	assign product = activationWide * weightWide;
	assign sum = accumulator + product;

	// bias moves up to the product's binary point.
	assign biasAligned = nnFixedPkg::accum_t'(mac.bias) <<< nnFixedPkg::fracBits;

	// negative sums clamp to zero, otherwise take the integer slice.
	assign rectified = sum[31] ? '0 : sum[sliceHigh:sliceLow];

	always_ff @(posedge clk)
	begin
		if (mac.clear)
		begin
			accumulator <= biasAligned;
		end
		else if (mac.accumulate)
		begin
			accumulator <= sum;
			mac.result <= rectified;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			accumulatePrev <= 1'b0;
		end
		else
		begin
			accumulatePrev <= mac.accumulate;
		end
	end

	// the falling edge of accumulate marks the last product taken.
	assign mac.resultValid = accumulatePrev & ~mac.accumulate;

endmodule

`default_nettype wire

/* logic/nnLayerTop.sv */
`timescale 1ns/1ps
`default_nettype none

module nnLayerTop (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [nnRegPkg::apbAddrWidth-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic weightWrite;
	logic biasWrite;
	logic inputWrite;
	logic [5:0] weightIndex;
	nnFixedPkg::neuronIndex_t biasIndex;
	nnFixedPkg::inputIndex_t inputIndex;
	nnFixedPkg::weight_t writeData;
	nnFixedPkg::neuronIndex_t readNeuron;
	nnFixedPkg::inputIndex_t readInput;
	nnFixedPkg::neuronIndex_t outputSelect;
	nnFixedPkg::activation_t storedActivation;
	nnFixedPkg::weight_t storedWeight;
	nnFixedPkg::weight_t storedBias;
	nnFixedPkg::activation_t outputValue;

	macBus macLink ();

	layerControl i_layerControl (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.weightWrite(weightWrite),
		.biasWrite(biasWrite),
		.inputWrite(inputWrite),
		.weightIndex(weightIndex),
		.biasIndex(biasIndex),
		.inputIndex(inputIndex),
		.writeData(writeData),
		.readNeuron(readNeuron),
		.readInput(readInput),
		.outputSelect(outputSelect),
		.storedActivation(storedActivation),
		.storedWeight(storedWeight),
		.storedBias(storedBias),
		.outputValue(outputValue),
		.mac(macLink.sequencer)
	);

	weightStore i_weightStore (
		.clk(clk),
		.weightWrite(weightWrite),
		.biasWrite(biasWrite),
		.weightIndex(weightIndex),
		.biasIndex(biasIndex),
		.writeData(writeData),
		.readNeuron(readNeuron),
		.readInput(readInput),
		.storedWeight(storedWeight),
		.storedBias(storedBias)
	);

	// activations share the 16-bit write bus with the weights.
	activationBuffer i_activationBuffer (
		.clk(clk),
		.reset(reset),
		.inputWrite(inputWrite),
		.inputIndex(inputIndex),
		.writeData(writeData),
		.readInput(readInput),
		.storedActivation(storedActivation),
		.readNeuron(readNeuron),
		.mac(macLink.mac),
		.outputSelect(outputSelect),
		.outputValue(outputValue)
	);

	neuronMac i_neuronMac (
		.clk(clk),
		.reset(reset),
		.mac(macLink.mac)
	);

endmodule

`default_nettype wire

/* sim/layerCases.svh */
`default_nettype none
`ifndef LAYER_CASES_SVH
`define LAYER_CASES_SVH

// value ranges used when the tables are filled at random.
typedef enum logic [1:0] {actSmall, actFull, actZero} actMode_t;
typedef enum logic [1:0] {weightSmall, weightMixed, weightNegative, weightLarge} weightMode_t;
typedef enum logic [1:0] {biasZero, biasMixed, biasPositive} biasMode_t;

// the extra transfer issued while the layer is running.
typedef enum logic [1:0] {busyStatusRead, busyWeightWrite, busyStart, busyInputWrite} busyKind_t;

typedef struct packed {
	actMode_t act;
	weightMode_t weight;
	biasMode_t bias;
	busyKind_t busyKind;
	logic expectError;
} layerCase_t;

localparam int caseCount = 8;

// columns are activations, weights, bias, busy transfer, expected pslverr.
localparam layerCase_t caseTable [caseCount] = '{
	'{actSmall, weightSmall, biasZero, busyStatusRead, 1'b0},
	'{actFull, weightMixed, biasMixed, busyWeightWrite, 1'b1},
	'{actFull, weightNegative, biasPositive, busyStart, 1'b1},
	'{actZero, weightMixed, biasMixed, busyStatusRead, 1'b0},
	'{actFull, weightLarge, biasPositive, busyInputWrite, 1'b1},
	'{actSmall, weightNegative, biasZero, busyWeightWrite, 1'b1},
	'{actFull, weightSmall, biasMixed, busyStart, 1'b1},
	'{actSmall, weightMixed, biasPositive, busyInputWrite, 1'b1}
};

`endif
`default_nettype wire

/* sim/nnLayerTb.sv */
`timescale 1ns/1ps
`include "layerCases.svh"
`default_nettype none

module nnLayerTb;

	localparam int readyLimit = 16;
	localparam int pollLimit = 60;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [nnRegPkg::apbAddrWidth-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	nnFixedPkg::activation_t inputTable [nnFixedPkg::inputCount];
	nnFixedPkg::weight_t weightTable [nnFixedPkg::neuronCount][nnFixedPkg::inputCount];
	nnFixedPkg::weight_t biasTable [nnFixedPkg::neuronCount];
	int checkCount;
	int errorCount;
	int testCount;
	int failedTests;
	int errorsAtStart;
	bit timedOut;

	nnLayerTop i_nnLayerTop (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #20 clk = ~clk;

	task automatic checkActivation(input string what, input nnFixedPkg::activation_t got,
		input nnFixedPkg::activation_t expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkStatus(input string what, input logic busyGot, input logic doneGot,
		input logic busyExpected, input logic doneExpected);
		checkCount++;
		if (busyGot !== busyExpected || doneGot !== doneExpected)
		begin
			errorCount++;
			$display("MISMATCH at %0t: %s busy %b done %b, expected busy %b done %b",
				$time, what, busyGot, doneGot, busyExpected, doneExpected);
		end
	endtask

	task automatic checkSlaveError(input string what, input logic got, input logic expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("MISMATCH at %0t: %s pslverr %b, expected %b",
				$time, what, got, expected);
		end
	endtask

	// a zero-wait APB transfer is sampled in the middle of its access cycle.
	task automatic apbTransfer(input logic write, input nnRegPkg::apbAddr_t addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		int waitCycles;
		rdata = '0;
		err = 1'b0;
		if (timedOut)
			return;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		waitCycles = 0;
		while (!pready && waitCycles < readyLimit)
		begin
			@(negedge clk);
			waitCycles++;
		end
		if (!pready)
		begin
			$display("timed out waiting for pready at address %h", addr);
			timedOut = 1'b1;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	function automatic nnRegPkg::apbAddr_t wordAddr(input nnRegPkg::apbAddr_t base,
		input int index);
		return nnRegPkg::apbAddr_t'(int'(base) + 4 * index);
	endfunction

	task automatic writeChecked(input nnRegPkg::apbAddr_t addr, input logic [31:0] data,
		input logic expectErr);
		logic [31:0] rdata;
		logic err;
		apbTransfer(1'b1, addr, data, rdata, err);
		checkSlaveError($sformatf("write %h", addr), err, expectErr);
	endtask

	task automatic readChecked(input nnRegPkg::apbAddr_t addr, input logic expectErr,
		output logic [31:0] data);
		logic err;
		apbTransfer(1'b0, addr, 32'h0, data, err);
		checkSlaveError($sformatf("read %h", addr), err, expectErr);
	endtask

	task automatic expectStatus(input string what, input logic busyExpected,
		input logic doneExpected);
		logic [31:0] data;
		readChecked(nnRegPkg::statusAddr, 1'b0, data);
		checkStatus(what, data[nnRegPkg::busyBit], data[nnRegPkg::doneBit],
			busyExpected, doneExpected);
	endtask

	task automatic waitLayerDone();
		logic [31:0] data;
		int polls;
		data = '0;
		polls = 0;
		while (!data[nnRegPkg::doneBit] && polls < pollLimit && !timedOut)
		begin
			readChecked(nnRegPkg::statusAddr, 1'b0, data);
			polls++;
		end
		if (!data[nnRegPkg::doneBit] && !timedOut)
		begin
			$display("timed out waiting for the layer to finish at %0t", $time);
			timedOut = 1'b1;
		end
	endtask

	function automatic nnFixedPkg::activation_t randomActivation(input actMode_t mode);
		case (mode)
			actSmall: return nnFixedPkg::activation_t'($urandom_range(255, 0));
			actFull: return nnFixedPkg::activation_t'($urandom());
			default: return '0;
		endcase
	endfunction

	function automatic nnFixedPkg::weight_t randomWeight(input weightMode_t mode);
		case (mode)
			weightSmall: return nnFixedPkg::weight_t'($urandom_range(8191, 0));
			weightMixed: return nnFixedPkg::weight_t'($urandom());
			weightNegative: return nnFixedPkg::weight_t'($urandom_range(65535, 32768));
			default: return nnFixedPkg::weight_t'($urandom_range(32767, 16384));
		endcase
	endfunction

	function automatic nnFixedPkg::weight_t randomBias(input biasMode_t mode);
		case (mode)
			biasZero: return '0;
			biasMixed: return nnFixedPkg::weight_t'($urandom());
			default: return nnFixedPkg::weight_t'($urandom_range(32767, 0));
		endcase
	endfunction

	// the sum of bias and products wraps at 32 bits and the rectifier keeps bits 28 to 13.
	function automatic nnFixedPkg::activation_t expectedOutput(input int n);
		logic [31:0] acc;
		acc = 32'(longint'(biasTable[n]) * 64'sd8192);
		for (int i = 0; i < nnFixedPkg::inputCount; i++)
		begin
			acc = acc + 32'(longint'(inputTable[i]) * longint'(weightTable[n][i]));
		end
		if (acc[31])
			return '0;
		return acc[28:13];
	endfunction

	task automatic fillTables(input layerCase_t row);
		for (int n = 0; n < nnFixedPkg::neuronCount; n++)
		begin
			for (int i = 0; i < nnFixedPkg::inputCount; i++)
			begin
				weightTable[n][i] = randomWeight(row.weight);
				writeChecked(wordAddr(nnRegPkg::weightBase, n * 16 + i),
					{16'h0, weightTable[n][i]}, 1'b0);
			end
			biasTable[n] = randomBias(row.bias);
			writeChecked(wordAddr(nnRegPkg::biasBase, n), {16'h0, biasTable[n]}, 1'b0);
		end
		for (int i = 0; i < nnFixedPkg::inputCount; i++)
		begin
			inputTable[i] = randomActivation(row.act);
			writeChecked(wordAddr(nnRegPkg::inputBase, i), {16'h0, inputTable[i]}, 1'b0);
		end
	endtask

	task automatic checkOutputs(input logic allZero);
		logic [31:0] data;
		for (int n = 0; n < nnFixedPkg::neuronCount; n++)
		begin
			readChecked(wordAddr(nnRegPkg::outputBase, n), 1'b0, data);
			checkActivation($sformatf("output %0d", n), data[15:0],
				allZero ? '0 : expectedOutput(n));
		end
	endtask

	task automatic runCase(input int index);
		layerCase_t row;
		logic [31:0] data;
		logic err;
		row = caseTable[index];
		fillTables(row);
		if (index > 0)
			expectStatus("before start", 1'b0, 1'b1);
		writeChecked(nnRegPkg::ctrlAddr, 32'h1, 1'b0);
		expectStatus("running", 1'b1, 1'b0);
		// neuron 3 and input 0 are still to be read by the sequencer at this point.
		case (row.busyKind)
			busyStatusRead: apbTransfer(1'b0, nnRegPkg::statusAddr, 32'h0, data, err);
			busyWeightWrite: apbTransfer(1'b1, wordAddr(nnRegPkg::weightBase, 48),
				{16'h0, ~weightTable[3][0]}, data, err);
			busyStart: apbTransfer(1'b1, nnRegPkg::ctrlAddr, 32'h1, data, err);
			default: apbTransfer(1'b1, nnRegPkg::inputBase, {16'h0, ~inputTable[0]}, data, err);
		endcase
		checkSlaveError("transfer while busy", err, row.expectError);
		waitLayerDone();
		expectStatus("finished", 1'b0, 1'b1);
		checkOutputs(1'b0);
	endtask

	task automatic checkUnmapped();
		nnRegPkg::apbAddr_t holes [6];
		logic [31:0] data;
		holes = '{12'h008, 12'h03C, 12'h07C, 12'h23C, 12'h042, 12'h800};
		foreach (holes[h])
		begin
			readChecked(holes[h], 1'b1, data);
			writeChecked(holes[h], 32'h0000_7fff, 1'b1);
		end
		writeChecked(nnRegPkg::statusAddr, 32'h3, 1'b1);
		writeChecked(nnRegPkg::outputBase, 32'h1234, 1'b1);
		// a rerun on the untouched tables must give the same results.
		writeChecked(nnRegPkg::ctrlAddr, 32'h1, 1'b0);
		waitLayerDone();
		checkOutputs(1'b0);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount != errorsAtStart || timedOut)
		begin
			failedTests++;
			$display("test %s failed", name);
		end
		else
			$display("test %s passed", name);
		errorsAtStart = errorCount;
	endtask

	initial
	begin
		void'($urandom(64485));
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		errorsAtStart = 0;
		timedOut = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		expectStatus("after reset", 1'b0, 1'b0);
		checkOutputs(1'b1);
		finishTest("reset state");
		for (int c = 0; c < caseCount && !timedOut; c++)
		begin
			runCase(c);
			finishTest($sformatf("case %0d", c));
		end
		if (!timedOut)
		begin
			checkUnmapped();
			finishTest("unmapped addresses");
		end
		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0 && !timedOut)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
logic/nnFixedPkg.sv
logic/nnRegPkg.sv
logic/macBus.sv
logic/layerControl.sv
logic/weightStore.sv
logic/activationBuffer.sv
logic/neuronMac.sv
logic/nnLayerTop.sv
sim/nnLayerTb.sv

/* run.sh */
#!/bin/sh
# Builds the layer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module nnLayerTb -o nnLayerSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/nnLayerSim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
